/* tinyCpu8.f */
logic/cpuPkg.sv
logic/controlSequencer.sv
logic/addressUnit.sv
logic/regFile.sv
logic/aluUnit.sv
logic/cpuTop.sv
tb/memoryModel.sv
tb/cpuTopTb.sv

/* tb/cpuTopTb.sv */
`timescale 1ns/1ps

module cpuTopTb;

    localparam int         numTests      = 13;
    localparam int         timeoutCycles = 64;
    localparam int         resetCycles   = 5;
    localparam logic [7:0] resultAddr    = 8'hF0;
    localparam logic [7:0] markerAddr    = 8'hF1;   // Wrong path store
    localparam logic [7:0] dataAddr      = 8'hE0;

    typedef struct packed {
        logic [95:0] name;
        logic [3:0]  op;
        logic [7:0]  a;
        logic [7:0]  b;
        logic        branch;      // BNE expected taken
        logic [7:0]  expAddr;
        logic [7:0]  expData;
        logic [7:0]  expCycle;    // Negedges after reset release
    } testEntry_t;

    logic          clock;
    logic          rstN;
    cpuPkg::byte_t memReadData;
    cpuPkg::addr_t memAddr;
    cpuPkg::byte_t memWriteData;
    logic          memWrite;

    testEntry_t  testTable [numTests];
    int          entryCount;
    logic [31:0] rngState;
    logic [7:0]  progAddr;
    int          passCount;
    int          failCount;
    int          i;

    cpuTop i_cpuTop (
        .clock        (clock),
        .rstN         (rstN),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite)
    );

    memoryModel dataMemory (
        .clock     (clock),
        .addr      (memAddr),
        .writeData (memWriteData),
        .write     (memWrite),
        .readData  (memReadData)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic testEntry_t makeEntry(input logic [95:0] name, input logic [3:0] op,
                                             input logic [7:0] a, input logic [7:0] b);
        testEntry_t e;
        e          = '0;
        e.name     = name;
        e.op       = op;
        e.a        = a;
        e.b        = b;
        e.expAddr  = resultAddr;
        e.expCycle = 8'd13;                // Three 3-cycle steps, then the store
        case (op)
            4'h0: e.expData = a & b;
            4'h1: e.expData = a | b;
            4'h2: e.expData = ~a;
            4'h3: e.expData = a + b;
            4'h4: e.expData = a - b;
            4'h5: e.expData = a >> 1;
            4'h6: e.expData = a << 1;
            4'hB: e.expData = a;
            4'h9: begin
                e.expData  = a;
                e.expCycle = 8'd10;
            end
            4'hA: begin
                e.branch   = (a != b);         // SUB result nonzero clears the flag
                e.expAddr  = e.branch ? resultAddr : markerAddr;
                e.expData  = e.branch ? b : a;
                e.expCycle = 8'd16;
            end
            4'hC: begin
                e.expData  = a;
                e.expCycle = 8'd8;
            end
            default: begin
                e.expData  = 8'h00;            // R0 straight out of reset
                e.expCycle = 8'd4;
            end
        endcase
        return e;
    endfunction

    function automatic logic [15:0] regInstr(input logic [3:0] op, input logic [1:0] rd,
                                             input logic [1:0] ra, input logic [1:0] rb);
        return {op, 2'b00, rd, 2'b00, ra, 2'b00, rb};
    endfunction

    function automatic logic [15:0] memInstr(input logic [3:0] op, input logic direct,
                                             input logic [1:0] r, input logic [7:0] low);
        return {op, 1'b0, direct, r, low};
    endfunction

    task automatic addEntry(input logic [95:0] name, input logic [3:0] op, input logic sameB);
        logic [7:0] a;
        logic [7:0] b;
        rngState = xorshift(rngState);
        a = rngState[7:0];
        b = rngState[15:8];
        if (sameB) begin
            b = a;
        end else if (op == 4'hA && a == b) begin
            b = ~a;
        end
        testTable[entryCount] = makeEntry(name, op, a, b);
        entryCount++;
    endtask

    task automatic emit(input logic [15:0] instr);
        dataMemory.putInstr(progAddr, instr);
        progAddr = progAddr + 8'd2;
    endtask

    task automatic buildProgram(input testEntry_t t);
        dataMemory.fillPattern();
        progAddr = 8'h00;
        case (t.op)
            4'hD: emit(memInstr(4'hD, 1'b1, 2'd0, resultAddr));
            4'hC: begin
                dataMemory.putByte(dataAddr, t.a);
                emit(memInstr(4'hC, 1'b1, 2'd3, dataAddr));
                emit(memInstr(4'hD, 1'b1, 2'd3, resultAddr));
            end
            4'h9: begin
                emit(memInstr(4'hC, 1'b0, 2'd1, t.a));
                emit(memInstr(4'h9, 1'b0, 2'd0, 8'h06));     // Jumps the marker store
                emit(memInstr(4'hD, 1'b1, 2'd1, markerAddr));
                emit(memInstr(4'hD, 1'b1, 2'd1, resultAddr));
            end
            4'hA: begin
                emit(memInstr(4'hC, 1'b0, 2'd1, t.a));
                emit(memInstr(4'hC, 1'b0, 2'd2, t.b));
                emit(regInstr(4'h4, 2'd3, 2'd1, 2'd2));
                emit(memInstr(4'hA, 1'b0, 2'd0, 8'h0A));
                emit(memInstr(4'hD, 1'b1, 2'd1, markerAddr));
                emit(memInstr(4'hD, 1'b1, 2'd2, resultAddr));
            end
            default: begin
                emit(memInstr(4'hC, 1'b0, 2'd1, t.a));
                emit(memInstr(4'hC, 1'b0, 2'd2, t.b));
                emit(regInstr(t.op, 2'd3, 2'd1, 2'd2));
                emit(memInstr(4'hD, 1'b1, 2'd3, resultAddr));
            end
        endcase
    endtask

    task automatic applyReset(input testEntry_t t, inout int errors);
        int c;
        @(posedge clock);
        rstN <= 1'b0;
        for (c = 0; c < resetCycles; c++) begin
            @(negedge clock);
            if (c == 0) begin
                buildProgram(t);                   // Core is held, bus is idle
            end
            if (memWrite !== 1'b0 || memAddr !== cpuPkg::resetPc) begin
                $display("ERROR %0s: in reset expected write 0 addr %h, actual write %b addr %h",
                         t.name, cpuPkg::resetPc, memWrite, memAddr);
                errors++;
            end
        end
        @(posedge clock);
        rstN <= 1'b1;
    endtask

    task automatic runTest(input testEntry_t t);
        int         errors;
        int         cycles;
        logic [7:0] seenAddr;
        logic [7:0] seenData;
        logic [7:0] otherAddr;
        logic [7:0] otherBefore;
        errors    = 0;
        cycles    = 0;
        otherAddr = t.expAddr ^ 8'h01;         // The other of the two store targets
        applyReset(t, errors);
        otherBefore = dataMemory.mem[otherAddr];
        do begin
            @(negedge clock);
            cycles++;
            if (cycles == 1 && memAddr !== cpuPkg::resetPc) begin
                $display("ERROR %0s: first fetch addr expected %h, actual %h",
                         t.name, cpuPkg::resetPc, memAddr);
                errors++;
            end
        end while (memWrite !== 1'b1 && cycles < timeoutCycles);
        if (memWrite !== 1'b1) begin
            $display("%0s: the core made no memory write within %0d cycles of reset release",
                     t.name, timeoutCycles);
            failCount++;
        end else begin
            seenAddr = memAddr;
            seenData = memWriteData;
            @(negedge clock);                  // Write edge has passed
            if (seenAddr !== t.expAddr) begin
                $display("ERROR %0s: store addr expected %h, actual %h",
                         t.name, t.expAddr, seenAddr);
                errors++;
            end
            if (seenData !== t.expData) begin
                $display("ERROR %0s: store data expected %h, actual %h",
                         t.name, t.expData, seenData);
                errors++;
            end
            if (cycles != t.expCycle) begin
                $display("ERROR %0s: store cycle expected %0d, actual %0d",
                         t.name, t.expCycle, cycles);
                errors++;
            end
            if (dataMemory.mem[t.expAddr] !== t.expData) begin
                $display("ERROR %0s: memory at %h expected %h, actual %h",
                         t.name, t.expAddr, t.expData, dataMemory.mem[t.expAddr]);
                errors++;
            end
            if (dataMemory.mem[otherAddr] !== otherBefore) begin
                $display("ERROR %0s: memory at %h expected %h, actual %h",
                         t.name, otherAddr, otherBefore, dataMemory.mem[otherAddr]);
                errors++;
            end
            if (errors == 0) begin
                $display("ok     %0s: %h written to %h in cycle %0d",
                         t.name, seenData, seenAddr, cycles);
                passCount++;
            end else begin
                $display("failed %0s: %0d mismatches", t.name, errors);
                failCount++;
            end
        end
    endtask

    initial begin
        rstN       = 1'b0;
        passCount  = 0;
        failCount  = 0;
        entryCount = 0;
        rngState   = 32'h82c0_3aea;
        dataMemory.fillPattern();

        addEntry("and", 4'h0, 1'b0);
        addEntry("or", 4'h1, 1'b0);
        addEntry("not", 4'h2, 1'b0);
        addEntry("add", 4'h3, 1'b0);
        addEntry("sub", 4'h4, 1'b0);
        addEntry("lsr", 4'h5, 1'b0);
        addEntry("lsl", 4'h6, 1'b0);
        addEntry("mov", 4'hB, 1'b0);
        addEntry("ldDirect", 4'hC, 1'b0);
        addEntry("bneTaken", 4'hA, 1'b0);
        addEntry("bneNotTaken", 4'hA, 1'b1);
        addEntry("bra", 4'h9, 1'b0);
        addEntry("stFirst", 4'hD, 1'b0);

        for (i = 0; i < entryCount; i++) begin
            runTest(testTable[i]);
        end

        $display("tests %0d, passed %0d, failed %0d", entryCount, passCount, failCount);
        if (failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb/memoryModel.sv */
`timescale 1ns/1ps

module memoryModel (
    input  logic          clock,
    input  cpuPkg::addr_t addr,
    input  cpuPkg::byte_t writeData,
    input  logic          write,
    output cpuPkg::byte_t readData
);

    cpuPkg::byte_t mem [256];

    assign readData = mem[addr];              // Same-cycle read

    always @(posedge clock) begin
        if (write) begin
            mem[addr] <= writeData;
        end
    end

    // Every byte differs from its neighbours
    task automatic fillPattern();
        int i;
        for (i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'hA5;
        end
    endtask

    task automatic putByte(input cpuPkg::addr_t a, input cpuPkg::byte_t d);
        mem[a] = d;
    endtask

    task automatic putInstr(input cpuPkg::addr_t a, input cpuPkg::instr_t instr);
        mem[a] = instr[15:8];                      // High byte first
        mem[a + cpuPkg::addr_t'(1)] = instr[7:0];
    endtask

endmodule

/* logic/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input  logic          clock,
    input  logic          rstN,
    input  cpuPkg::byte_t memReadData,
    output cpuPkg::addr_t memAddr,
    output cpuPkg::byte_t memWriteData,
    output logic          memWrite
);

    cpuPkg::ctrlWord_t ctrl;
    cpuPkg::byte_t     operandA;
    cpuPkg::byte_t     operandB;
    cpuPkg::byte_t     aluResult;
    logic              zeroFlag;

    controlSequencer i_controlSequencer (
        .clock       (clock),
        .rstN        (rstN),
        .memReadData (memReadData),
        .zeroFlag    (zeroFlag),
        .ctrl        (ctrl),
        .memWrite    (memWrite)
    );

    addressUnit i_addressUnit (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .memAddr (memAddr)
    );

    regFile i_regFile (
        .clock       (clock),
        .rstN        (rstN),
        .ctrl        (ctrl),
        .aluResult   (aluResult),
        .memReadData (memReadData),
        .operandA    (operandA),
        .operandB    (operandB)
    );

    aluUnit i_aluUnit (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .operandA  (operandA),
        .operandB  (operandB),
        .aluResult (aluResult),
        .zeroFlag  (zeroFlag)
    );

    assign memWriteData = operandB;   // ST source via read port B

endmodule

/* logic/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  logic              clock,
    input  logic              rstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::byte_t     operandA,
    input  cpuPkg::byte_t     operandB,
    output cpuPkg::byte_t     aluResult,
    output logic              zeroFlag
);

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluAnd: begin
                aluResult = operandA & operandB;
            end
            cpuPkg::aluOr: begin
                aluResult = operandA | operandB;
            end
            cpuPkg::aluNot: begin
                aluResult = ~operandA;
            end
            cpuPkg::aluAdd: begin
                aluResult = operandA + operandB;   // Wraps mod 256
            end
            cpuPkg::aluSub: begin
                aluResult = operandA - operandB;
            end
            cpuPkg::aluLsr: begin
                aluResult = {1'b0, operandA[7:1]};
            end
            cpuPkg::aluLsl: begin
                aluResult = {operandA[6:0], 1'b0};
            end
            default: begin
                aluResult = operandA;              // MOV
            end
        endcase
    end

    // Holds its value across branches and memory ops
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            zeroFlag <= 1'b0;
        end else if (ctrl.flagUpdate) begin
            zeroFlag <= (aluResult == '0);
        end
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic              clock,
    input  logic              rstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::byte_t     aluResult,
    input  cpuPkg::byte_t     memReadData,
    output cpuPkg::byte_t     operandA,
    output cpuPkg::byte_t     operandB
);

    cpuPkg::byte_t regQ [cpuPkg::numRegs];
    cpuPkg::byte_t writeData;

    always_comb begin
        case (ctrl.regInSel)
            cpuPkg::inImmediate: begin
                writeData = ctrl.imm;
            end
            cpuPkg::inMemory: begin
                writeData = memReadData;      // LD direct
            end
            default: begin
                writeData = aluResult;
            end
        endcase
    end

    for (genvar i = 0; i < cpuPkg::numRegs; i++) begin : gSlot
        logic          slotWrite;
        cpuPkg::byte_t value;

        assign slotWrite = ctrl.regWrite && (ctrl.regDst == cpuPkg::regIdx_t'(i));

        always_ff @(posedge clock or negedge rstN) begin
            if (!rstN) begin
                value <= '0;
            end else if (slotWrite) begin
                value <= writeData;
            end
        end

        assign regQ[i] = value;
    end

    // Read ports
    assign operandA = regQ[ctrl.regSrcA];
    assign operandB = regQ[ctrl.regSrcB];

endmodule

/* logic/addressUnit.sv */
`timescale 1ns/1ps

module addressUnit (
    input  logic              clock,
    input  logic              rstN,
    input  cpuPkg::ctrlWord_t ctrl,
    output cpuPkg::addr_t     memAddr
);

    cpuPkg::addr_t pc;
    cpuPkg::addr_t ar;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= cpuPkg::resetPc;
        end else if (ctrl.pcLoad) begin
            pc <= ctrl.imm;                   // Branch target
        end else if (ctrl.pcInc) begin
            pc <= pc + cpuPkg::addr_t'(1);
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            ar <= '0;
        end else if (ctrl.arLoad) begin
            ar <= ctrl.imm;
        end
    end

    always_comb begin
        case (ctrl.addrSel)
            cpuPkg::fromAr: begin
                memAddr = ar;
            end
            default: begin
                memAddr = pc;
            end
        endcase
    end

    // Fetch steps and branches never overlap
    assert property (@(posedge clock) disable iff (!rstN)
        !(ctrl.pcInc && ctrl.pcLoad));

endmodule

/* logic/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer (
    input  logic              clock,
    input  logic              rstN,
    input  cpuPkg::byte_t     memReadData,
    input  logic              zeroFlag,
    output cpuPkg::ctrlWord_t ctrl,
    output logic              memWrite
);

    cpuPkg::seqState_t state;
    cpuPkg::seqState_t nextState;
    cpuPkg::instr_t    ir;
    cpuPkg::opcode_t   opcode;
    logic              directMode;

    assign opcode     = cpuPkg::opcode_t'(ir[15:12]);
    assign directMode = ir[10];           // LD mode bit

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::fetchHigh;
            ir    <= '0;
        end else begin
            state <= nextState;
            if (state == cpuPkg::fetchHigh) begin
                ir[15:8] <= memReadData;  // High byte first
            end
            if (state == cpuPkg::fetchLow) begin
                ir[7:0] <= memReadData;
            end
        end
    end

    always_comb begin
        ctrl          = '0;
        ctrl.regDst   = ir[9:8];          // Also the LD/ST register field
        ctrl.regSrcA  = ir[5:4];
        ctrl.regSrcB  = ir[1:0];
        ctrl.regInSel = cpuPkg::inAlu;
        ctrl.aluOp    = cpuPkg::aluPassA;
        ctrl.addrSel  = cpuPkg::fromPc;
        ctrl.imm      = ir[7:0];
        memWrite      = 1'b0;
        nextState     = cpuPkg::fetchHigh;

        case (state)
            cpuPkg::fetchHigh: begin
                ctrl.pcInc = 1'b1;
                nextState  = cpuPkg::fetchLow;
            end
            cpuPkg::fetchLow: begin
                ctrl.pcInc = 1'b1;
                nextState  = cpuPkg::execute;
            end
            cpuPkg::execute: begin
                case (opcode)
                    cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opNot, cpuPkg::opAdd,
                    cpuPkg::opSub, cpuPkg::opLsr, cpuPkg::opLsl: begin
                        ctrl.regWrite   = 1'b1;
                        ctrl.flagUpdate = 1'b1;
                        ctrl.aluOp      = cpuPkg::aluOp_t'(ir[14:12]);
                    end
                    cpuPkg::opMov: begin
                        ctrl.regWrite   = 1'b1;
                        ctrl.flagUpdate = 1'b1;
                        ctrl.aluOp      = cpuPkg::aluPassA;
                    end
                    cpuPkg::opBra: begin
                        ctrl.pcLoad = 1'b1;
                    end
                    cpuPkg::opBne: begin
                        ctrl.pcLoad = !zeroFlag;
                    end
                    cpuPkg::opLd: begin
                        if (directMode) begin
                            ctrl.arLoad = 1'b1;
                            nextState   = cpuPkg::memAccess;
                        end else begin
                            ctrl.regWrite = 1'b1;
                            ctrl.regInSel = cpuPkg::inImmediate;
                        end
                    end
                    cpuPkg::opSt: begin
                        ctrl.arLoad = 1'b1;
                        nextState   = cpuPkg::memAccess;
                    end
                    default: begin
                        ctrl.regWrite = 1'b0;  // No-op
                    end
                endcase
            end
            cpuPkg::memAccess: begin
                ctrl.addrSel = cpuPkg::fromAr;
                ctrl.regSrcB = ir[9:8];     // Store data register
                if (opcode == cpuPkg::opLd) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regInSel = cpuPkg::inMemory;
                end
                if (opcode == cpuPkg::opSt) begin
                    memWrite = 1'b1;
                end
            end
        endcase
    end

    // A store is a single-cycle strobe in memAccess
    assert property (@(posedge clock) disable iff (!rstN)
        memWrite |-> (state == cpuPkg::memAccess) ##1 !memWrite);

    assert property (@(posedge clock) disable iff (!rstN)
        (state == cpuPkg::memAccess) |-> $past(state) == cpuPkg::execute);

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  addr_t;
    typedef logic [15:0] instr_t;
    typedef logic [1:0]  regIdx_t;

    localparam int    numRegs = 4;
    localparam addr_t resetPc = 8'h00;

    // Opcodes 7, 8, E and F run as no-ops
    typedef enum logic [3:0] {
        opAnd  = 4'h0,
        opOr   = 4'h1,
        opNot  = 4'h2,
        opAdd  = 4'h3,
        opSub  = 4'h4,
        opLsr  = 4'h5,
        opLsl  = 4'h6,
        opInc  = 4'h7,
        opDec  = 4'h8,
        opBra  = 4'h9,
        opBne  = 4'hA,
        opMov  = 4'hB,
        opLd   = 4'hC,
        opSt   = 4'hD,
        opPull = 4'hE,
        opPush = 4'hF
    } opcode_t;

    // Same order as opcodes 0 to 6
    typedef enum logic [2:0] {
        aluAnd,
        aluOr,
        aluNot,
        aluAdd,
        aluSub,
        aluLsr,
        aluLsl,
        aluPassA
    } aluOp_t;

    typedef enum logic [1:0] {
        inAlu,
        inImmediate,
        inMemory
    } regInSel_t;

    typedef enum logic [1:0] {
        fetchHigh,
        fetchLow,
        execute,
        memAccess
    } seqState_t;

    typedef enum logic {
        fromPc,
        fromAr
    } addrSel_t;

    typedef struct packed {
        logic      regWrite;
        regIdx_t   regDst;
        regIdx_t   regSrcA;
        regIdx_t   regSrcB;
        regInSel_t regInSel;
        aluOp_t    aluOp;
        logic      flagUpdate;
        logic      pcInc;
        logic      pcLoad;
        logic      arLoad;
        addrSel_t  addrSel;
        byte_t     imm;          // Address or immediate field
    } ctrlWord_t;

endpackage
